//--- hdl/poly_pkg.sv
`default_nettype none

package poly_pkg;

	localparam int AXI_ADDR_W = 8;
	localparam int AXI_DATA_W = 32;

	typedef logic [15:0] coeff_t;    // coefficient or argument x
	typedef logic [31:0] acc_t;      // sum and monomial wrap modulo 2^32
	typedef logic [4:0] degree_t;

	localparam degree_t DEGREE_UNDEF = 5'd31;

	localparam logic [31:0] STATUS_BUSY = 32'hFFFF_FFFF;
	localparam logic [31:0] STATUS_OK = 32'd0;
	localparam logic [31:0] STATUS_ERR_DEGREE = 32'd2;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 8'h00;
	localparam logic [AXI_ADDR_W-1:0] REG_X = 8'h04;
	localparam logic [AXI_ADDR_W-1:0] REG_RESULT = 8'h08;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h0C;
	localparam logic [AXI_ADDR_W-1:0] REG_DEGREE = 8'h10;
	localparam logic [AXI_ADDR_W-1:0] REG_COEFF = 8'h14;

	// ************************************************************************
	// one table write word, seen as a degree entry or a coefficient entry
	// ************************************************************************
	typedef struct packed {
		logic [18:0] rsvd_hi;
		degree_t degree;                 // bits 12 to 8
		logic [4:0] rsvd_lo;
		logic [2:0] poly;                // bits 2 to 0
	} deg_word_t;

	typedef struct packed {
		logic [7:0] rsvd_hi;
		logic [3:0] index;               // bits 23 to 20
		logic rsvd_lo;
		logic [2:0] poly;                // bits 18 to 16
		coeff_t value;
	} coeff_word_t;

	typedef union packed {
		deg_word_t deg;
		coeff_word_t coeff;
	} table_word_u;

endpackage

`default_nettype wire

//--- hdl/poly_if.sv
`timescale 1ns/1ps
`default_nettype none

// control path between the register block and the evaluator
interface eval_if #(
	parameter int NUM_POLYS = 8
);
	import poly_pkg::*;

	logic start;                         // one cycle pulse
	logic [$clog2(NUM_POLYS)-1:0] poly_sel;
	coeff_t x;
	logic busy;
	logic done;                          // one cycle pulse, result and status valid
	acc_t result;
	logic [31:0] status;

	modport regs (output start, poly_sel, x, input busy, done, result, status);
	modport eval (input start, poly_sel, x, output busy, done, result, status);
endinterface

// table access, writes from the register block and reads from the evaluator
interface table_if #(
	parameter int NUM_POLYS = 8,
	parameter int MAX_TERMS = 11
);
	import poly_pkg::*;

	logic deg_we;
	logic coeff_we;
	table_word_u wdata;
	logic [$clog2(NUM_POLYS)-1:0] rd_poly;
	logic [$clog2(MAX_TERMS)-1:0] rd_index;
	degree_t degree;                     // registered, one cycle after rd_poly
	coeff_t coeff;

	modport regs (output deg_we, coeff_we, wdata);
	modport tables (input deg_we, coeff_we, wdata, rd_poly, rd_index, output degree, coeff);
	modport eval (output rd_poly, rd_index, input degree, coeff);
endinterface

`default_nettype wire

//--- hdl/poly_regs.sv
`timescale 1ns/1ps
`default_nettype none

module poly_regs #(
	parameter int NUM_POLYS = 8
) (
	input logic clk,
	input logic rst,

	input logic [poly_pkg::AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [poly_pkg::AXI_DATA_W-1:0] wdata,
	input logic [poly_pkg::AXI_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	input logic [poly_pkg::AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [poly_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	eval_if.regs ev,
	table_if.regs tb
);
	import poly_pkg::*;

	localparam int SEL_W = $clog2(NUM_POLYS);
	localparam int LANES = AXI_DATA_W / 8;

	logic wr_fire;
	logic rd_fire;
	logic [AXI_DATA_W-1:0] lane_mask;
	logic [AXI_DATA_W-1:0] rd_word;
	acc_t result_q;
	logic [31:0] status_q;

	function automatic logic [AXI_DATA_W-1:0] strb_mask(input logic [LANES-1:0] strb);
		logic [AXI_DATA_W-1:0] m;
		for (int i = 0; i < LANES; i++)
			m[8*i +: 8] = {8{strb[i]}};
		return m;
	endfunction

	// ************************************************************************
	// write channel
	// ************************************************************************
	assign wr_fire = awvalid && wvalid && !bvalid;    // address and data taken together
	assign awready = wr_fire;
	assign wready = wr_fire;
	assign bresp = RESP_OKAY;
	assign lane_mask = strb_mask(wstrb);

	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			bvalid <= 1'b0;
			ev.start <= 1'b0;
			ev.poly_sel <= '0;
			ev.x <= '0;
			tb.deg_we <= 1'b0;
			tb.coeff_we <= 1'b0;
			result_q <= '0;
			status_q <= STATUS_BUSY;
		end
		else
		begin
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			// a start request while the evaluator runs is dropped
			ev.start <= wr_fire && (awaddr == REG_CTRL) && wstrb[0] && wdata[0]
				&& !ev.busy;

			if (wr_fire && (awaddr == REG_CTRL) && wstrb[0])
				ev.poly_sel <= wdata[4 +: SEL_W];
			if (wr_fire && (awaddr == REG_X))
				ev.x <= (ev.x & ~lane_mask[15:0]) | (wdata[15:0] & lane_mask[15:0]);

			tb.deg_we <= wr_fire && (awaddr == REG_DEGREE) && (&wstrb);  // full words only
			tb.coeff_we <= wr_fire && (awaddr == REG_COEFF) && (&wstrb);

			if (ev.start)
				status_q <= STATUS_BUSY;
			if (ev.done)
			begin
				result_q <= ev.result;
				status_q <= ev.status;
			end
		end

	always_ff @(posedge clk)
		if (wr_fire)
			tb.wdata <= wdata;

	// ************************************************************************
	// read channel
	// ************************************************************************
	assign arready = !rvalid;
	assign rd_fire = arvalid && arready;
	assign rresp = RESP_OKAY;

	always_comb
		case (araddr)
			REG_RESULT: rd_word = result_q;
			REG_STATUS: rd_word = status_q;
			default: rd_word = '0;            // write only and unmapped offsets read 0
		endcase

	always_ff @(posedge clk or negedge rst)
		if (!rst)
			rvalid <= 1'b0;
		else if (rd_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;

	always_ff @(posedge clk)
		if (rd_fire)
			rdata <= rd_word;                 // held while rready is low

endmodule

`default_nettype wire

//--- hdl/poly_tables.sv
`timescale 1ns/1ps
`default_nettype none

module poly_tables #(
	parameter int NUM_POLYS = 8,
	parameter int MAX_TERMS = 11
) (
	input logic clk,
	input logic rst,
	table_if.tables tb
);
	import poly_pkg::*;

	localparam int PW = $clog2(NUM_POLYS);

	degree_t deg_mem [NUM_POLYS];
	coeff_t coeff_mem [NUM_POLYS][MAX_TERMS];
	logic deg_ok;
	logic coeff_ok;

	// entries outside the table are dropped
	assign deg_ok = tb.deg_we && (tb.wdata.deg.poly < NUM_POLYS);
	assign coeff_ok = tb.coeff_we && (tb.wdata.coeff.poly < NUM_POLYS)
		&& (tb.wdata.coeff.index < MAX_TERMS);

	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			for (int p = 0; p < NUM_POLYS; p++)
			begin
				deg_mem[p] <= DEGREE_UNDEF;          // every polynomial starts undefined
				for (int t = 0; t < MAX_TERMS; t++)
					coeff_mem[p][t] <= '0;
			end
			tb.degree <= DEGREE_UNDEF;
			tb.coeff <= '0;
		end
		else
		begin
			if (deg_ok)
				deg_mem[tb.wdata.deg.poly[PW-1:0]] <= tb.wdata.deg.degree;
			if (coeff_ok)
				coeff_mem[tb.wdata.coeff.poly[PW-1:0]][tb.wdata.coeff.index] <=
					tb.wdata.coeff.value;

			tb.degree <= deg_mem[tb.rd_poly];
			tb.coeff <= coeff_mem[tb.rd_poly][tb.rd_index];
		end

endmodule

`default_nettype wire

//--- hdl/poly_eval.sv
`timescale 1ns/1ps
`default_nettype none

module poly_eval #(
	parameter int NUM_POLYS = 8,
	parameter int MAX_TERMS = 11
) (
	input logic clk,
	input logic rst,
	eval_if.eval ev,
	table_if.eval tb
);
	import poly_pkg::*;

	localparam int IW = $clog2(MAX_TERMS);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_RD_DEG = 3'd1;
	localparam logic [2:0] S_CHK_DEG = 3'd2;
	localparam logic [2:0] S_RD_COEFF = 3'd3;
	localparam logic [2:0] S_ACC = 3'd4;
	localparam logic [2:0] S_MUL = 3'd5;
	localparam logic [2:0] S_ERR = 3'd6;
	localparam logic [2:0] S_END = 3'd7;

	logic [2:0] state;
	logic [2:0] next_state;
	logic [$clog2(NUM_POLYS)-1:0] sel_q;
	logic [IW-1:0] idx;
	coeff_t x_q;
	degree_t deg_q;
	acc_t monomial;
	acc_t sum;
	acc_t term_sum;
	logic deg_bad;
	logic last_term;

	assign tb.rd_poly = sel_q;
	assign tb.rd_index = idx;
	assign ev.busy = (state != S_IDLE);
	assign ev.done = (state == S_END);

	assign deg_bad = (tb.degree == DEGREE_UNDEF) || (tb.degree >= MAX_TERMS);
	assign term_sum = sum + monomial * tb.coeff;     // wraps modulo 2^32
	assign last_term = (idx == deg_q);

	// ************************************************************************
	// next state
	// ************************************************************************
	always_comb
	begin
		next_state = state;
		case (state)
			S_IDLE:
				if (ev.start)
					next_state = S_RD_DEG;
			S_RD_DEG: next_state = S_CHK_DEG;        // degree arrives one cycle later
			S_CHK_DEG: next_state = deg_bad ? S_ERR : S_RD_COEFF;
			S_RD_COEFF: next_state = S_ACC;
			S_ACC: next_state = last_term ? S_END : S_MUL;
			S_MUL: next_state = S_RD_COEFF;
			S_ERR: next_state = S_END;
			default: next_state = S_IDLE;            // S_END
		endcase
	end

	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			state <= S_IDLE;
			sel_q <= '0;
			idx <= '0;
			ev.result <= '0;
			ev.status <= STATUS_BUSY;
		end
		else
		begin
			state <= next_state;
			case (state)
				S_IDLE:
					if (ev.start)
						sel_q <= ev.poly_sel;
				S_CHK_DEG: idx <= '0;
				S_ACC:
					if (last_term)
					begin
						ev.result <= term_sum;
						ev.status <= STATUS_OK;
					end
					else
						idx <= idx + 1'b1;
				S_ERR:
				begin
					ev.result <= '0;
					ev.status <= STATUS_ERR_DEGREE;
				end
				default: ;
			endcase
		end

	// the monomial is x to the power idx when its coefficient arrives
	always_ff @(posedge clk)
		case (state)
			S_IDLE:
				if (ev.start)
					x_q <= ev.x;
			S_CHK_DEG:
			begin
				deg_q <= tb.degree;
				sum <= '0;
				monomial <= 32'd1;
			end
			S_ACC: sum <= term_sum;
			S_MUL: monomial <= monomial * x_q;
			default: ;
		endcase

endmodule

`default_nettype wire

//--- hdl/poly_top.sv
`timescale 1ns/1ps
`default_nettype none

module poly_top #(
	parameter int NUM_POLYS = 8,
	parameter int MAX_TERMS = 11
) (
	input logic clk,
	input logic rst,

	input logic [poly_pkg::AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [poly_pkg::AXI_DATA_W-1:0] wdata,
	input logic [poly_pkg::AXI_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	input logic [poly_pkg::AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [poly_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	eval_if #(.NUM_POLYS(NUM_POLYS)) ev_bus ();
	table_if #(.NUM_POLYS(NUM_POLYS), .MAX_TERMS(MAX_TERMS)) tbl_bus ();

	// host side registers, sits beside the evaluator it steers
	poly_regs #(.NUM_POLYS(NUM_POLYS)) poly_regs_inst (
		.clk, .rst,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.ev(ev_bus.regs),
		.tb(tbl_bus.regs)
	);

	poly_tables #(.NUM_POLYS(NUM_POLYS), .MAX_TERMS(MAX_TERMS)) poly_tables_inst (
		.clk, .rst,
		.tb(tbl_bus.tables)
	);

	poly_eval #(.NUM_POLYS(NUM_POLYS), .MAX_TERMS(MAX_TERMS)) poly_eval_inst (
		.clk, .rst,
		.ev(ev_bus.eval),
		.tb(tbl_bus.eval)
	);

endmodule

`default_nettype wire

//--- verification/poly_tb.sv
`timescale 1ns/1ps
`default_nettype none

module poly_tb;
	import poly_pkg::*;

	localparam int NUM_POLYS = 8;
	localparam int MAX_TERMS = 11;
	localparam int TIMEOUT = 200;

	logic clk;
	logic rst;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [31:0] rng;
	coeff_t coeffs [NUM_POLYS][MAX_TERMS];        // copy of what the host loaded
	int degrees [NUM_POLYS];

	poly_top #(.NUM_POLYS(NUM_POLYS), .MAX_TERMS(MAX_TERMS)) poly_top_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// sum of c_i times x to the power i, wrapping at 32 bits
	function automatic acc_t poly_value(input int p, input coeff_t xv);
		acc_t sum;
		acc_t mono;
		sum = '0;
		mono = 32'd1;
		for (int i = 0; i <= degrees[p]; i++)
		begin
			sum = sum + mono * acc_t'(coeffs[p][i]);
			mono = mono * acc_t'(xv);
		end
		return sum;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "wrong value in %s", name);
		end
	endtask

	task automatic timeout_stop(input string what);
		$display("timeout while waiting for %s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout while waiting for %s", what);
	endtask

	// ************************************************************************
	// AXI4-Lite host tasks where stall holds bready or rready low for that many cycles
	// ************************************************************************
	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int stall);
		int n;
		@(posedge clk);
		#1;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (stall == 0);
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!awready && n < TIMEOUT);
		if (!awready)
			timeout_stop("awready");
		check_value("wready with awready", 32'd1, 32'(wready));
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!bvalid && n < TIMEOUT);
		if (!bvalid)
			timeout_stop("bvalid");
		check_value("write response", 32'(RESP_OKAY), 32'(bresp));
		if (stall > 0)
		begin
			for (int i = 0; i < stall; i++)
			begin
				@(negedge clk);
				check_value("bvalid under back-pressure", 32'd1, 32'(bvalid));
			end
			@(posedge clk);
			#1;
			bready = 1'b1;
		end
		@(posedge clk);                           // response accepted here
		#1;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data, input int stall);
		int n;
		@(posedge clk);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		rready = (stall == 0);
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!arready && n < TIMEOUT);
		if (!arready)
			timeout_stop("arready");
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!rvalid && n < TIMEOUT);
		if (!rvalid)
			timeout_stop("rvalid");
		data = rdata;
		check_value("read response", 32'(RESP_OKAY), 32'(rresp));
		if (stall > 0)
		begin
			for (int i = 0; i < stall; i++)
			begin
				@(negedge clk);
				check_value("rvalid under back-pressure", 32'd1, 32'(rvalid));
				check_value("rdata under back-pressure", data, rdata);
			end
			@(posedge clk);
			#1;
			rready = 1'b1;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic wait_done(output logic [31:0] status);
		int n;
		n = 0;
		do
		begin
			axi_read(REG_STATUS, status, 0);
			n++;
		end
		while (status == STATUS_BUSY && n < TIMEOUT);
		if (status == STATUS_BUSY)
			timeout_stop("the evaluation to finish");
	endtask

	// ************************************************************************
	// table loading and evaluation runs
	// ************************************************************************
	task automatic load_poly(input int p, input int deg);
		degrees[p] = deg;
		axi_write(REG_DEGREE, {19'd0, 5'(deg), 5'd0, 3'(p)}, 0);
		for (int i = 0; i <= deg; i++)
		begin
			rng = xorshift32(rng);
			coeffs[p][i] = rng[15:0];
			axi_write(REG_COEFF, {8'd0, 4'(i), 1'b0, 3'(p), coeffs[p][i]}, 0);
		end
	endtask

	task automatic run_eval(input int p, input coeff_t xv, input int stall, input string name);
		logic [31:0] status;
		logic [31:0] result;
		axi_write(REG_X, 32'(xv), stall);
		axi_write(REG_CTRL, (32'(p) << 4) | 32'd1, 0);
		wait_done(status);
		axi_read(REG_RESULT, result, 0);
		check_value({name, " status"}, STATUS_OK, status);
		check_value({name, " result"}, poly_value(p, xv), result);
	endtask

	task automatic run_error(input int p, input string name);
		logic [31:0] value;
		axi_write(REG_CTRL, (32'(p) << 4) | 32'd1, 0);
		wait_done(value);
		check_value({name, " status"}, STATUS_ERR_DEGREE, value);
		axi_read(REG_RESULT, value, 0);
		check_value({name, " result"}, 32'd0, value);
	endtask

	initial
	begin
		logic [31:0] value;
		coeff_t xv;
		rng = 32'd86;
		rst = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b1;

		axi_read(REG_STATUS, value, 0);
		check_value("reset status", STATUS_BUSY, value);
		axi_read(REG_RESULT, value, 0);
		check_value("reset result", 32'd0, value);
		axi_read(REG_X, value, 0);
		check_value("read of REG_X", 32'd0, value);

		load_poly(0, 0);
		load_poly(1, 1);
		load_poly(2, 5);
		load_poly(3, 10);
		for (int p = 0; p < 4; p++)
			for (int k = 0; k < 3; k++)
			begin
				rng = xorshift32(rng);
				run_eval(p, rng[15:0], 0, "evaluation");
			end

		run_error(7, "undefined degree");
		axi_write(REG_DEGREE, {19'd0, 5'd11, 5'd0, 3'd6}, 0);
		run_error(6, "degree too large");

		// a second start during a degree 10 run must be dropped
		rng = xorshift32(rng);
		xv = rng[15:0];
		axi_write(REG_X, 32'(xv), 0);
		axi_write(REG_CTRL, (32'd3 << 4) | 32'd1, 0);
		axi_read(REG_STATUS, value, 0);
		check_value("status while busy", STATUS_BUSY, value);
		axi_write(REG_CTRL, (32'd2 << 4) | 32'd1, 0);
		wait_done(value);
		check_value("busy start status", STATUS_OK, value);
		axi_read(REG_RESULT, value, 0);
		check_value("busy start result", poly_value(3, xv), value);
		axi_read(REG_STATUS, value, 0);
		check_value("status after dropped start", STATUS_OK, value);

		// x is write only and reads back as 0 even when loaded
		axi_write(REG_X, 32'h0000_A5C3, 0);
		axi_read(REG_X, value, 0);
		check_value("read of written REG_X", 32'd0, value);

		rng = xorshift32(rng);
		run_eval(1, rng[15:0], 4, "write back-pressure");
		axi_read(REG_RESULT, value, 5);
		check_value("read back-pressure", poly_value(1, rng[15:0]), value);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hdl/poly_pkg.sv
hdl/poly_if.sv
hdl/poly_regs.sv
hdl/poly_tables.sv
hdl/poly_eval.sv
hdl/poly_top.sv
verification/poly_tb.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module poly_tb -Mdir obj_dir -o poly_sim

run: build
	./obj_dir/poly_sim

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module poly_top

clean:
	rm -rf obj_dir
